//--- source/cop_pkg.sv
package cop_pkg;

    typedef logic [31:0] word_t;          // Operand and writeback data
    typedef logic [3:0]  byte_en_t;       // Writeback byte enable
    typedef logic [4:0]  reg_idx_t;       // Destination register index
    typedef logic [3:0]  cop_class_t;
    typedef logic [4:0]  cop_subclass_t;
    typedef logic [2:0]  aes_op_t;        // Decoded AES operation

    // Instruction class and AES subclass encodings
    localparam cop_class_t    CLASS_AES         = 4'b1000;

    localparam cop_subclass_t SCLASS_SUB_ENC    = 5'b00001;
    localparam cop_subclass_t SCLASS_SUB_ENCROT = 5'b00010;
    localparam cop_subclass_t SCLASS_SUB_DEC    = 5'b00011;
    localparam cop_subclass_t SCLASS_SUB_DECROT = 5'b00100;
    localparam cop_subclass_t SCLASS_MIX_ENC    = 5'b00101;
    localparam cop_subclass_t SCLASS_MIX_DEC    = 5'b00110;

    // Operation codes carried from decode to execute
    localparam aes_op_t OP_NONE       = 3'd0;
    localparam aes_op_t OP_SUB_ENC    = 3'd1;
    localparam aes_op_t OP_SUB_ENCROT = 3'd2;
    localparam aes_op_t OP_SUB_DEC    = 3'd3;
    localparam aes_op_t OP_SUB_DECROT = 3'd4;
    localparam aes_op_t OP_MIX_ENC    = 3'd5;
    localparam aes_op_t OP_MIX_DEC    = 3'd6;

    typedef struct packed {
        cop_class_t    op_class;     // [31:28]
        cop_subclass_t op_subclass;  // [27:23]
        logic [10:0]   spare;        // [22:12]
        reg_idx_t      rd;           // [11:7]
        logic [6:0]    opcode;       // [6:0]
    } cop_instr_t;

    typedef struct packed {
        logic     valid;
        aes_op_t  op;
        reg_idx_t rd;
        word_t    rs1;
        word_t    rs2;
    } aes_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        byte_en_t ben;
        word_t    wdata;
    } aes_rsp_t;

endpackage

//--- source/cop_decode.sv
`timescale 1ns/10ps

module cop_decode (
    input  logic                g_clk,
    input  logic                rst_n,
    input  logic                ivalid,
    input  cop_pkg::cop_instr_t instr,
    input  cop_pkg::word_t      rs1,
    input  cop_pkg::word_t      rs2,
    output cop_pkg::aes_req_t   req
);
    import cop_pkg::*;

    aes_op_t op_d;  // Operation decoded from the current word

    always_comb begin
        op_d = OP_NONE;
        if (instr.op_class == CLASS_AES) begin
            case (instr.op_subclass)
                SCLASS_SUB_ENC:    op_d = OP_SUB_ENC;
                SCLASS_SUB_ENCROT: op_d = OP_SUB_ENCROT;
                SCLASS_SUB_DEC:    op_d = OP_SUB_DEC;
                SCLASS_SUB_DECROT: op_d = OP_SUB_DECROT;
                SCLASS_MIX_ENC:    op_d = OP_MIX_ENC;
                SCLASS_MIX_DEC:    op_d = OP_MIX_DEC;
                default:           op_d = OP_NONE;  // Unused AES subclass
            endcase
        end
    end

    // Payload follows the valid bit into execute
    always_ff @(posedge g_clk) begin
        req.op  <= op_d;
        req.rd  <= instr.rd;
        req.rs1 <= rs1;
        req.rs2 <= rs2;
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= ivalid;
        end
    end

    // One request per strobe, one cycle later
    assert property (@(posedge g_clk) disable iff (!rst_n)
        $past(rst_n) |-> (req.valid == $past(ivalid)))
        else $error("cop_decode: req.valid does not follow ivalid");

endmodule

//--- source/aes_sbox.sv
`timescale 1ns/10ps

module aes_sbox (
    input  logic [7:0] in,
    input  logic       inv,
    output logic [7:0] out
);

    logic [7:0] field_in;  // Value handed to the inversion
    logic [7:0] recip;

    // GF(2^8) multiply, reduced by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] t;
        p = 8'h00;
        t = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ t;
            end
            t = {t[6:0], 1'b0} ^ (t[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    function automatic logic [7:0] rotl(input logic [7:0] x, input int unsigned n);
        return (x << n) | (x >> (8 - n));
    endfunction

    // a^254 by an addition chain, zero stays zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] a2;
        logic [7:0] a3;
        logic [7:0] a6;
        logic [7:0] a12;
        logic [7:0] a15;
        logic [7:0] a30;
        logic [7:0] a60;
        logic [7:0] a120;
        logic [7:0] a240;
        a2   = gf_mul(a, a);
        a3   = gf_mul(a2, a);
        a6   = gf_mul(a3, a3);
        a12  = gf_mul(a6, a6);
        a15  = gf_mul(a12, a3);
        a30  = gf_mul(a15, a15);
        a60  = gf_mul(a30, a30);
        a120 = gf_mul(a60, a60);
        a240 = gf_mul(a120, a120);
        return gf_mul(gf_mul(a240, a12), a2);  // 240 + 12 + 2
    endfunction

    function automatic logic [7:0] affine_fwd(input logic [7:0] x);
        return x ^ rotl(x, 1) ^ rotl(x, 2) ^ rotl(x, 3) ^ rotl(x, 4) ^ 8'h63;
    endfunction

    function automatic logic [7:0] affine_inv(input logic [7:0] x);
        return rotl(x, 1) ^ rotl(x, 3) ^ rotl(x, 6) ^ 8'h05;
    endfunction

    // Inverse direction undoes the affine map before inverting
    assign field_in = inv ? affine_inv(in) : in;
    assign recip    = gf_inv(field_in);
    assign out      = inv ? recip : affine_fwd(recip);

endmodule

//--- source/aes_unit.sv
`timescale 1ns/10ps

module aes_unit (
    input  cop_pkg::aes_req_t req,
    output cop_pkg::aes_rsp_t rsp
);
    import cop_pkg::*;

    logic  is_sub;
    logic  is_mix;
    logic  dec_mode;  // Inverse S-box or InvMixColumns
    logic  rotate;

    word_t sbox_in;
    word_t sbox_out;
    word_t sub_word;
    word_t mix_col;   // Row 0 in the low byte
    word_t mix_word;
    logic [15:0] mix_coef;

    assign is_sub   = (req.op == OP_SUB_ENC) || (req.op == OP_SUB_ENCROT) ||
                      (req.op == OP_SUB_DEC) || (req.op == OP_SUB_DECROT);
    assign is_mix   = (req.op == OP_MIX_ENC) || (req.op == OP_MIX_DEC);
    assign dec_mode = (req.op == OP_SUB_DEC) || (req.op == OP_SUB_DECROT) ||
                      (req.op == OP_MIX_DEC);
    assign rotate   = (req.op == OP_SUB_ENCROT) || (req.op == OP_SUB_DECROT);

    // Bytes alternate between the two sources, idle when not a sub op
    assign sbox_in = {32{is_sub}} &
                     {req.rs2[31:24], req.rs1[23:16], req.rs2[15:8], req.rs1[7:0]};

    aes_sbox sbox_0 (.in(sbox_in[7:0]),   .inv(dec_mode), .out(sbox_out[7:0]));
    aes_sbox sbox_1 (.in(sbox_in[15:8]),  .inv(dec_mode), .out(sbox_out[15:8]));
    aes_sbox sbox_2 (.in(sbox_in[23:16]), .inv(dec_mode), .out(sbox_out[23:16]));
    aes_sbox sbox_3 (.in(sbox_in[31:24]), .inv(dec_mode), .out(sbox_out[31:24]));

    assign sub_word = rotate ? {sbox_out[23:0], sbox_out[31:24]} : sbox_out;

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Multiply by a 4-bit constant using repeated xtime
    function automatic logic [7:0] gmul(input logic [7:0] b, input logic [3:0] c);
        logic [7:0] x2;
        logic [7:0] x4;
        logic [7:0] x8;
        x2 = xtime(b);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return ({8{c[0]}} & b) ^ ({8{c[1]}} & x2) ^ ({8{c[2]}} & x4) ^ ({8{c[3]}} & x8);
    endfunction

    assign mix_col  = {req.rs2[31:24], req.rs2[23:16], req.rs1[15:8], req.rs1[7:0]};
    assign mix_coef = dec_mode ? 16'h9dbe : 16'h1132;  // First matrix row, k0 lowest

    // Each row is the first row rotated right by its index
    always_comb begin : mix_calc
        logic [7:0] acc;
        mix_word = '0;
        for (int r = 0; r < 4; r++) begin
            acc = 8'h00;
            for (int j = 0; j < 4; j++) begin
                acc = acc ^ gmul(mix_col[8*j +: 8], mix_coef[4*((j - r) & 3) +: 4]);
            end
            mix_word[8*r +: 8] = acc;
        end
    end

    always_comb begin
        rsp.valid = req.valid;
        rsp.rd    = req.rd;
        rsp.ben   = (req.op != OP_NONE) ? 4'hf : 4'h0;
        if (is_sub) begin
            rsp.wdata = sub_word;
        end else if (is_mix) begin
            rsp.wdata = mix_word;
        end else begin
            rsp.wdata = '0;
        end
    end

    // Whole-word writes only
    always_comb begin
        if (rsp.valid) begin
            assert (rsp.ben == 4'h0 || rsp.ben == 4'hf)
                else $error("aes_unit: partial byte enable %h", rsp.ben);
        end
    end

endmodule

//--- source/cop_result.sv
`timescale 1ns/10ps

module cop_result (
    input  logic              g_clk,
    input  logic              rst_n,
    input  cop_pkg::aes_rsp_t rsp,
    output logic              idone,
    output cop_pkg::reg_idx_t rd_idx,
    output cop_pkg::byte_en_t rd_ben,
    output cop_pkg::word_t    rd_wdata
);
    import cop_pkg::*;

    always_ff @(posedge g_clk) begin
        rd_idx   <= rsp.rd;
        rd_wdata <= rsp.wdata;
        if (!rst_n) begin
            idone  <= 1'b0;
            rd_ben <= '0;
        end else begin
            idone  <= rsp.valid;
            rd_ben <= rsp.valid ? rsp.ben : byte_en_t'(0);  // No stale enable
        end
    end

    // Writeback enable only alongside the done pulse
    assert property (@(posedge g_clk) disable iff (!rst_n)
        (rd_ben != '0) |-> idone)
        else $error("cop_result: rd_ben %h without idone", rd_ben);

endmodule

//--- source/crypto_cop.sv
`timescale 1ns/10ps

module crypto_cop (
    input  logic                g_clk,
    input  logic                rst_n,
    input  logic                ivalid,
    input  cop_pkg::cop_instr_t instr,
    input  cop_pkg::word_t      rs1,
    input  cop_pkg::word_t      rs2,
    output logic                idone,
    output cop_pkg::reg_idx_t   rd_idx,
    output cop_pkg::byte_en_t   rd_ben,
    output cop_pkg::word_t      rd_wdata
);
    import cop_pkg::*;

    aes_req_t req;  // Decode to execute
    aes_rsp_t rsp;  // Execute to result

    cop_decode u_decode (
        .g_clk  (g_clk),
        .rst_n  (rst_n),
        .ivalid (ivalid),
        .instr  (instr),
        .rs1    (rs1),
        .rs2    (rs2),
        .req    (req)
    );

    aes_unit u_aes (
        .req (req),
        .rsp (rsp)
    );

    cop_result u_result (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .rsp      (rsp),
        .idone    (idone),
        .rd_idx   (rd_idx),
        .rd_ben   (rd_ben),
        .rd_wdata (rd_wdata)
    );

endmodule

//--- include/aes_ref.svh
`ifndef AES_REF_SVH
`define AES_REF_SVH

function automatic logic [7:0] ref_xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] ref_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] t;
    p = 8'h00;
    t = a;
    for (int i = 0; i < 8; i++) begin
        p = b[i] ? (p ^ t) : p;
        t = ref_xtime(t);
    end
    return p;
endfunction

// Inverse found by search, affine map applied bit by bit
function automatic logic [7:0] ref_sbox(input logic [7:0] x);
    logic [7:0] y;
    logic [7:0] s;
    y = 8'h00;
    for (int c = 1; c < 256; c++) begin
        if (ref_mul(x, 8'(c)) == 8'h01) y = 8'(c);
    end
    for (int i = 0; i < 8; i++) begin
        s[i] = y[i] ^ y[(i + 4) % 8] ^ y[(i + 5) % 8] ^ y[(i + 6) % 8] ^ y[(i + 7) % 8];
    end
    return s ^ 8'h63;
endfunction

function automatic logic [7:0] ref_inv_sbox(input logic [7:0] x);
    logic [7:0] r;
    r = 8'h00;
    for (int c = 0; c < 256; c++) begin
        if (ref_sbox(8'(c)) == x) r = 8'(c);
    end
    return r;
endfunction

// Column packed with row 0 in bits 7:0
function automatic logic [31:0] ref_mix_col(input logic [31:0] c, input bit inv);
    logic [7:0] k [4];
    logic [31:0] r;
    if (inv) begin
        k = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
    end else begin
        k = '{8'h02, 8'h03, 8'h01, 8'h01};
    end
    r = '0;
    for (int row = 0; row < 4; row++) begin
        for (int j = 0; j < 4; j++) begin
            r[8*row +: 8] = r[8*row +: 8] ^ ref_mul(c[8*j +: 8], k[(j - row + 4) % 4]);
        end
    end
    return r;
endfunction

`endif

//--- verification/tb_crypto_cop.sv
`timescale 1ns/10ps

module tb_crypto_cop;
    import cop_pkg::*;

    `include "aes_ref.svh"

    typedef struct packed {
        logic       valid;
        logic [2:0] test;
        reg_idx_t   rd;
        byte_en_t   ben;
        word_t      wdata;
    } expect_t;

    localparam int MAX_CYCLES = 400;  // 6 x (40 + 4) plus reset and gaps

    logic       g_clk;
    logic       rst_n;
    logic       ivalid;
    cop_instr_t instr;
    word_t      rs1;
    word_t      rs2;
    logic       idone;
    reg_idx_t   rd_idx;
    byte_en_t   rd_ben;
    word_t      rd_wdata;

    expect_t     exp_in;        // Aligned with ivalid
    expect_t     exp_mid = '0;
    expect_t     exp_out = '0;  // Aligned with idone
    logic [7:0]  sbox_tbl [256];
    logic [7:0]  inv_tbl [256];
    logic [31:0] lcg_state = 32'h60b9;
    int          cyc = 0;
    int          errors = 0;
    int          err_base = 0;
    int          passed = 0;
    int          failed = 0;
    logic [2:0]  cur_test = '0;
    string       test_names [6] = '{"sub_enc_dec", "sub_rot", "mix", "non_aes",
                                    "back_to_back", "reset"};

    crypto_cop uut (.*);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        exp_mid <= exp_in;
        exp_out <= exp_mid;
        cyc     <= cyc + 1;
        if (cyc == MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bit is_aes_op(input cop_class_t cls, input cop_subclass_t sc);
        return (cls == CLASS_AES) && (sc >= SCLASS_SUB_ENC) && (sc <= SCLASS_MIX_DEC);
    endfunction

    function automatic word_t expect_wdata(input cop_class_t cls, input cop_subclass_t sc,
                                           input word_t a, input word_t b);
        bit    inv;
        word_t sel;
        word_t s;
        inv = (sc == SCLASS_SUB_DEC) || (sc == SCLASS_SUB_DECROT);
        sel = {b[31:24], a[23:16], b[15:8], a[7:0]};  // s3 s2 s1 s0 inputs
        for (int i = 0; i < 4; i++) begin
            s[8*i +: 8] = inv ? inv_tbl[sel[8*i +: 8]] : sbox_tbl[sel[8*i +: 8]];
        end
        if (!is_aes_op(cls, sc)) return '0;
        case (sc)
            SCLASS_SUB_ENC, SCLASS_SUB_DEC:       return s;
            SCLASS_SUB_ENCROT, SCLASS_SUB_DECROT: return {s[23:0], s[31:24]};
            default: return ref_mix_col({b[31:16], a[15:0]}, sc == SCLASS_MIX_DEC);
        endcase
    endfunction

    task automatic report_mismatch(input string field, input logic [2:0] test,
                                   input logic [31:0] exp_v, input logic [31:0] act_v);
        errors = errors + 1;
        $display("MISMATCH %s %s: expected %h, actual %h", test_names[test], field, exp_v, act_v);
    endtask

    task automatic issue(input cop_class_t cls, input cop_subclass_t sc, input word_t a,
                         input word_t b, input word_t wexp, input bit counted);
        cop_instr_t w;
        w = next_rand();  // Random spare, rd and opcode bits
        w.op_class    = cls;
        w.op_subclass = sc;
        ivalid <= 1'b1;
        instr  <= w;
        rs1    <= a;
        rs2    <= b;
        exp_in <= '{counted, cur_test, w.rd, is_aes_op(cls, sc) ? 4'hf : 4'h0, wexp};
        @(posedge g_clk);
    endtask

    task automatic send(input cop_class_t cls, input cop_subclass_t sc);
        word_t a;
        word_t b;
        a = next_rand();
        b = next_rand();
        issue(cls, sc, a, b, expect_wdata(cls, sc, a, b), 1'b1);
    endtask

    task automatic send_random();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd6:    send(CLASS_AES ^ cop_class_t'(r[5:4] | 2'b01), r[12:8]);  // Foreign class
            3'd7:    send(CLASS_AES, {2'b11, r[6:4]});  // Unused subclass
            default: send(CLASS_AES, 5'(r[2:0]) + 5'd1);
        endcase
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            ivalid <= 1'b0;
            exp_in <= '{valid: 1'b0, test: cur_test, default: '0};
            @(posedge g_clk);
        end
    endtask

    task automatic finish_test();
        idle(4);  // Drain both pipeline stages
        if (errors == err_base) passed++;
        else failed++;
        $display("%s finished with %0d errors", test_names[cur_test], errors - err_base);
        err_base = errors;
        cur_test = cur_test + 3'd1;
    endtask

    assert property (@(posedge g_clk) (cyc >= 2) |-> (idone === exp_out.valid))
        else begin
            errors = errors + 1;
            $display("%s: %s", test_names[$sampled(exp_out.test)], $sampled(exp_out.valid) ?
                     "no idone for an issued instruction" : "idone with no instruction issued");
        end
    assert property (@(posedge g_clk) (cyc >= 2 && exp_out.valid) |-> (rd_idx === exp_out.rd))
        else report_mismatch("rd_idx", $sampled(exp_out.test), $sampled(exp_out.rd),
                             $sampled(rd_idx));
    assert property (@(posedge g_clk) (cyc >= 2 && exp_out.valid) |-> (rd_ben === exp_out.ben))
        else report_mismatch("rd_ben", $sampled(exp_out.test), $sampled(exp_out.ben),
                             $sampled(rd_ben));
    assert property (@(posedge g_clk)
        (cyc >= 2 && exp_out.valid) |-> (rd_wdata === exp_out.wdata))
        else report_mismatch("rd_wdata", $sampled(exp_out.test), $sampled(exp_out.wdata),
                             $sampled(rd_wdata));
    assert property (@(posedge g_clk) (cyc >= 2 && !exp_out.valid) |-> (rd_ben === 4'h0))
        else begin
            errors = errors + 1;
            $display("%s: rd_ben raised with no result due", test_names[$sampled(exp_out.test)]);
        end

    initial begin
        word_t col;
        word_t m;
        word_t a;
        word_t b;
        rst_n  = 1'b0;
        ivalid = 1'b0;
        instr  = '0;
        rs1    = '0;
        rs2    = '0;
        exp_in = '0;
        for (int i = 0; i < 256; i++) begin
            sbox_tbl[i] = ref_sbox(8'(i));
            inv_tbl[i]  = ref_inv_sbox(8'(i));
        end
        repeat (4) @(posedge g_clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 40; i++) begin
            send(CLASS_AES, (i % 2) ? SCLASS_SUB_DEC : SCLASS_SUB_ENC);
        end
        finish_test();
        for (int i = 0; i < 40; i++) begin
            send(CLASS_AES, (i % 2) ? SCLASS_SUB_DECROT : SCLASS_SUB_ENCROT);
        end
        finish_test();
        // Forward column, then its image fed back through the inverse
        for (int i = 0; i < 20; i++) begin
            col = next_rand();
            a   = next_rand();
            b   = next_rand();
            m   = ref_mix_col(col, 1'b0);
            issue(CLASS_AES, SCLASS_MIX_ENC, {a[31:16], col[15:0]}, {col[31:16], b[15:0]}, m, 1'b1);
            issue(CLASS_AES, SCLASS_MIX_DEC, {b[31:16], m[15:0]}, {m[31:16], a[15:0]}, col, 1'b1);
        end
        finish_test();
        for (int i = 0; i < 40; i++) begin
            a = next_rand();
            if (i % 2) send(CLASS_AES, {2'b11, a[2:0]});
            else send(CLASS_AES ^ cop_class_t'(a[1:0] | 2'b01), a[8:4]);
        end
        finish_test();
        for (int i = 0; i < 40; i++) begin
            send_random();
            idle(int'(next_rand() % 2));
        end
        finish_test();
        // Last strobe is still in flight when reset arrives
        issue(CLASS_AES, SCLASS_SUB_ENC, next_rand(), next_rand(), '0, 1'b0);
        rst_n <= 1'b0;  // Strobes during reset must be dropped
        repeat (4) issue(CLASS_AES, SCLASS_SUB_ENC, next_rand(), next_rand(), '0, 1'b0);
        rst_n <= 1'b1;
        idle(1);
        repeat (36) send_random();
        finish_test();

        $display("Summary: %0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- crypto_cop.f
+incdir+include
source/cop_pkg.sv
source/cop_decode.sv
source/aes_sbox.sv
source/aes_unit.sv
source/cop_result.sv
source/crypto_cop.sv
verification/tb_crypto_cop.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_crypto_cop
RTL_TOP   ?= crypto_cop
FLIST     ?= crypto_cop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/10ps -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
